/* include/evacc_config.svh */
`ifndef EVACC_CONFIG_SVH
`define EVACC_CONFIG_SVH

// event geometry for the memclk side of the accumulator

// number of SURF streams feeding one TURFIO
`define EVACC_NUM_SURFS 7

// 64-bit words that each SURF sends per chunk
`define EVACC_SAMPLES 384

// chunks per event
// the low bit of the chunk number picks the bank
`define EVACC_CHUNKS 4

// width of one SURF word and of the payload data
`define EVACC_DATA_W 64

// address width inside one bank
// 7 x 384 = 2688 words fit in 4096
`define EVACC_BANK_AW 12

`endif

/* source/evacc_pkg.sv */
`include "evacc_config.svh"

package evacc_pkg;

    // narrow index types
    typedef logic [$clog2(`EVACC_CHUNKS)-1:0]    chunk_num_t;
    typedef logic [$clog2(`EVACC_NUM_SURFS)-1:0] surf_idx_t;
    typedef logic [$clog2(`EVACC_SAMPLES)-1:0]   sample_idx_t;

    // one word from a SURF stream
    typedef struct packed {
        logic                     valid;
        logic [`EVACC_DATA_W-1:0] data;
    } surf_beat_t;

    // write request into the chunk buffer, no handshake
    typedef struct packed {
        logic                      en;
        logic                      bank;
        logic [`EVACC_BANK_AW-1:0] addr;
        logic [`EVACC_DATA_W-1:0]  data;
    } buf_wr_t;

    // read request, data comes back one cycle later
    typedef struct packed {
        logic                      en;
        logic                      bank;
        logic [`EVACC_BANK_AW-1:0] addr;
    } buf_rd_t;

    // chunk number sits above the SURF index
    typedef struct packed {
        chunk_num_t chunk;
        surf_idx_t  surf;
    } payload_ident_t;

    typedef struct packed {
        logic                     valid;
        logic                     last;
        payload_ident_t           ident;
        logic [`EVACC_DATA_W-1:0] data;
    } payload_t;

endpackage

/* source/surf_write_sequencer.sv */
`timescale 1ns/100ps
`include "evacc_config.svh"

module surf_write_sequencer (
    input  logic                                          memclk,
    input  logic                                          memresetn,
    input  evacc_pkg::surf_beat_t [`EVACC_NUM_SURFS-1:0] surf_i,
    output logic [`EVACC_NUM_SURFS-1:0]                  surf_ready_o,
    input  logic [1:0]                                    bank_full_i,
    output evacc_pkg::buf_wr_t                            buf_wr_o,
    output logic                                          chunk_push_o,
    output evacc_pkg::chunk_num_t                         chunk_num_o
);

    localparam int NS      = `EVACC_NUM_SURFS;
    localparam int SAMPLES = `EVACC_SAMPLES;
    localparam int CHUNKS  = `EVACC_CHUNKS;
    localparam int AW      = `EVACC_BANK_AW;

    // write states are contiguous so the SURF index is state - S_WR0
    typedef enum logic [3:0] {
        S_IDLE,
        S_GATHER,
        S_WR0,
        S_WR1,
        S_WR2,
        S_WR3,
        S_WR4,
        S_WR5,
        S_WR6,
        S_SIGNAL,
        S_BANK_WAIT
    } state_t;

    state_t                  state;
    evacc_pkg::sample_idx_t  sample_cnt;
    evacc_pkg::chunk_num_t   chunk_cnt;
    evacc_pkg::surf_idx_t    widx;
    logic                    in_write;
    logic                    all_valid;
    logic [AW-1:0]           wr_addr;

    // a round starts only when every stream has a word waiting
    always_comb begin
        all_valid = 1'b1;
        for (int k = 0; k < NS; k++) begin
            all_valid &= surf_i[k].valid;
        end
    end

    // which SURF the current write state serves
    always_comb begin
        in_write = (state >= S_WR0) && (state <= S_WR6);
        widx     = in_write ? evacc_pkg::surf_idx_t'(state - S_WR0) : '0;
    end

    // bank layout is SURF index x 384 + sample
    assign wr_addr = AW'(widx) * AW'(SAMPLES) + AW'(sample_cnt);

    // one ready bit at a time, and only over a valid word
    always_comb begin
        for (int k = 0; k < NS; k++) begin
            surf_ready_o[k] = in_write && (widx == evacc_pkg::surf_idx_t'(k)) &&
                              surf_i[k].valid;
        end
    end

    // the accepted word goes straight into the buffer on the same edge
    always_comb begin
        buf_wr_o.en   = in_write && surf_i[widx].valid;
        buf_wr_o.bank = chunk_cnt[0];
        buf_wr_o.addr = wr_addr;
        buf_wr_o.data = surf_i[widx].data;
    end

    assign chunk_push_o = (state == S_SIGNAL);
    assign chunk_num_o  = chunk_cnt;

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            state      <= S_IDLE;
            sample_cnt <= '0;
            chunk_cnt  <= '0;
        end else begin
            case (state)
                // start of an event
                S_IDLE: begin
                    sample_cnt <= '0;
                    chunk_cnt  <= '0;
                    state      <= S_BANK_WAIT;
                end
                // hold off until the readout frees this chunk's bank
                S_BANK_WAIT: begin
                    if (!bank_full_i[chunk_cnt[0]]) begin
                        state <= S_GATHER;
                    end
                end
                S_GATHER: begin
                    if (all_valid) begin
                        state <= S_WR0;
                    end
                end
                // end of a round
                S_WR6: begin
                    if (sample_cnt == evacc_pkg::sample_idx_t'(SAMPLES - 1)) begin
                        sample_cnt <= '0;
                        state      <= S_SIGNAL;
                    end else begin
                        sample_cnt <= sample_cnt + 1'b1;
                        state      <= S_GATHER;
                    end
                end
                // chunk pushed to the queue during this cycle
                S_SIGNAL: begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                    if (chunk_cnt == evacc_pkg::chunk_num_t'(CHUNKS - 1)) begin
                        state <= S_IDLE;
                    end else begin
                        state <= S_BANK_WAIT;
                    end
                end
                // S_WR0 to S_WR5 simply step to the next SURF
                default: begin
                    state <= state_t'(state + 1'b1);
                end
            endcase
        end
    end

    // gathered words stay valid until taken
    // so each write state handshakes exactly one stream and no other state handshakes any
    a_ready_onehot: assert property (
        @(posedge memclk) disable iff (!memresetn)
        in_write ? $onehot(surf_ready_o) : (surf_ready_o == '0)
    );

endmodule

/* source/chunk_buffer.sv */
`timescale 1ns/100ps
`include "evacc_config.svh"

module chunk_buffer (
    input  logic                      memclk,
    input  logic                      memresetn,
    input  evacc_pkg::buf_wr_t        buf_wr_i,
    input  evacc_pkg::buf_rd_t        buf_rd_i,
    input  logic                      release_i,
    input  logic                      release_bank_i,
    output logic [`EVACC_DATA_W-1:0] rd_data_o,
    output logic [1:0]                bank_full_o
);

    localparam int AW = `EVACC_BANK_AW;
    localparam int DW = `EVACC_DATA_W;

    // bank bit on top of the in-bank address
    logic [DW-1:0] mem [2**(AW+1)];

    // simple dual port, registered read
    always_ff @(posedge memclk) begin
        if (buf_wr_i.en) begin
            mem[{buf_wr_i.bank, buf_wr_i.addr}] <= buf_wr_i.data;
        end
        if (buf_rd_i.en) begin
            rd_data_o <= mem[{buf_rd_i.bank, buf_rd_i.addr}];
        end
    end

    // a bank is busy from its first write until the readout lets it go
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            bank_full_o <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (release_i && (release_bank_i == 1'(b))) begin
                    bank_full_o[b] <= 1'b0;
                end else if (buf_wr_i.en && (buf_wr_i.bank == 1'(b))) begin
                    bank_full_o[b] <= 1'b1;
                end
            end
        end
    end

    // writer and readout never touch the same bank at a release
    a_no_write_on_release: assert property (
        @(posedge memclk) disable iff (!memresetn)
        release_i |-> !(buf_wr_i.en && (buf_wr_i.bank == release_bank_i))
    );

endmodule

/* source/chunk_queue.sv */
`timescale 1ns/100ps

module chunk_queue (
    input  logic                  memclk,
    input  logic                  memresetn,
    input  logic                  push_i,
    input  evacc_pkg::chunk_num_t push_num_i,
    input  logic                  pop_i,
    output evacc_pkg::chunk_num_t head_o,
    output logic                  head_valid_o
);

    localparam int DEPTH = 4;
    localparam int PW    = $clog2(DEPTH);

    evacc_pkg::chunk_num_t fifo_mem [DEPTH];
    logic [PW-1:0]         wr_ptr;
    logic [PW-1:0]         rd_ptr;
    logic [PW:0]           count;
    logic                  do_pop;

    // popping an empty queue is ignored
    assign do_pop       = pop_i && (count != '0);
    assign head_o       = fifo_mem[rd_ptr];
    assign head_valid_o = (count != '0);

    always_ff @(posedge memclk) begin
        if (push_i) begin
            fifo_mem[wr_ptr] <= push_num_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // two banks bound the chunks in flight, so this never fills
    a_no_push_full: assert property (
        @(posedge memclk) disable iff (!memresetn)
        push_i |-> (count != (PW+1)'(DEPTH))
    );

endmodule

/* source/chunk_readout.sv */
`timescale 1ns/100ps
`include "evacc_config.svh"

module chunk_readout (
    input  logic                      memclk,
    input  logic                      memresetn,
    input  evacc_pkg::chunk_num_t     head_i,
    input  logic                      head_valid_i,
    output logic                      pop_o,
    input  logic                      payload_has_space_i,
    output evacc_pkg::buf_rd_t        buf_rd_o,
    input  logic [`EVACC_DATA_W-1:0] rd_data_i,
    output logic                      release_o,
    output logic                      release_bank_o,
    output evacc_pkg::payload_t       payload_o
);

    localparam int NS      = `EVACC_NUM_SURFS;
    localparam int SAMPLES = `EVACC_SAMPLES;
    localparam int AW      = `EVACC_BANK_AW;

    logic                      active;
    evacc_pkg::chunk_num_t     cur_chunk;
    evacc_pkg::surf_idx_t      surf_cnt;
    evacc_pkg::sample_idx_t    sample_cnt;
    logic [AW-1:0]             rd_addr;
    logic                      block_end;
    logic                      chunk_end;
    // stage that lines up with the buffer's read register
    logic                      stage_valid;
    logic                      stage_last;
    evacc_pkg::payload_ident_t stage_ident;

    assign block_end = (sample_cnt == evacc_pkg::sample_idx_t'(SAMPLES - 1));
    assign chunk_end = block_end && (surf_cnt == evacc_pkg::surf_idx_t'(NS - 1));

    // start a chunk only when the consumer can take all of it
    assign pop_o = !active && head_valid_i && payload_has_space_i;

    // reads walk the bank linearly, SURF blocks back to back
    always_comb begin
        buf_rd_o.en   = active;
        buf_rd_o.bank = cur_chunk[0];
        buf_rd_o.addr = rd_addr;
    end

    always_ff @(posedge memclk) begin
        if (pop_o) begin
            cur_chunk <= head_i;
        end
    end

    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            active     <= 1'b0;
            surf_cnt   <= '0;
            sample_cnt <= '0;
            rd_addr    <= '0;
        end else if (pop_o) begin
            active     <= 1'b1;
            surf_cnt   <= '0;
            sample_cnt <= '0;
            rd_addr    <= '0;
        end else if (active) begin
            rd_addr <= rd_addr + 1'b1;
            if (block_end) begin
                sample_cnt <= '0;
                surf_cnt   <= surf_cnt + 1'b1;
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
            // last read of the chunk
            if (chunk_end) begin
                active <= 1'b0;
            end
        end
    end

    // valid and release are control, tag bits ride along
    always_ff @(posedge memclk) begin
        if (!memresetn) begin
            stage_valid <= 1'b0;
            release_o   <= 1'b0;
        end else begin
            stage_valid <= active;
            // one cycle after the final word leaves
            release_o   <= stage_valid && stage_last &&
                           (stage_ident.surf == evacc_pkg::surf_idx_t'(NS - 1));
        end
    end

    always_ff @(posedge memclk) begin
        stage_last        <= active && block_end;
        stage_ident.chunk <= cur_chunk;
        stage_ident.surf  <= surf_cnt;
        release_bank_o    <= stage_ident.chunk[0];
    end

    // data comes straight from the buffer register
    always_comb begin
        payload_o.valid = stage_valid;
        payload_o.last  = stage_last;
        payload_o.ident = stage_ident;
        payload_o.data  = rd_data_i;
    end

endmodule

/* source/event_accumulator.sv */
`timescale 1ns/100ps
`include "evacc_config.svh"

module event_accumulator (
    input  logic                                          memclk,
    input  logic                                          memresetn,
    input  evacc_pkg::surf_beat_t [`EVACC_NUM_SURFS-1:0] surf_i,
    output logic [`EVACC_NUM_SURFS-1:0]                  surf_ready_o,
    output evacc_pkg::payload_t                           payload_o,
    input  logic                                          payload_has_space_i
);

    // sequencer to buffer and queue
    evacc_pkg::buf_wr_t        buf_wr;
    logic [1:0]                bank_full;
    logic                      chunk_push;
    evacc_pkg::chunk_num_t     chunk_num;
    // queue to readout
    evacc_pkg::chunk_num_t     head;
    logic                      head_valid;
    logic                      pop;
    // readout to buffer
    evacc_pkg::buf_rd_t        buf_rd;
    logic [`EVACC_DATA_W-1:0] rd_data;
    logic                      release_pulse;
    logic                      release_bank;

    surf_write_sequencer u_seq (
        .memclk       (memclk),
        .memresetn    (memresetn),
        .surf_i       (surf_i),
        .surf_ready_o (surf_ready_o),
        .bank_full_i  (bank_full),
        .buf_wr_o     (buf_wr),
        .chunk_push_o (chunk_push),
        .chunk_num_o  (chunk_num)
    );

    chunk_buffer u_buf (
        .memclk         (memclk),
        .memresetn      (memresetn),
        .buf_wr_i       (buf_wr),
        .buf_rd_i       (buf_rd),
        .release_i      (release_pulse),
        .release_bank_i (release_bank),
        .rd_data_o      (rd_data),
        .bank_full_o    (bank_full)
    );

    chunk_queue u_queue (
        .memclk       (memclk),
        .memresetn    (memresetn),
        .push_i       (chunk_push),
        .push_num_i   (chunk_num),
        .pop_i        (pop),
        .head_o       (head),
        .head_valid_o (head_valid)
    );

    chunk_readout u_rd (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .head_i              (head),
        .head_valid_i        (head_valid),
        .pop_o               (pop),
        .payload_has_space_i (payload_has_space_i),
        .buf_rd_o            (buf_rd),
        .rd_data_i           (rd_data),
        .release_o           (release_pulse),
        .release_bank_o      (release_bank),
        .payload_o           (payload_o)
    );

endmodule

/* tests/event_accumulator_tb.sv */
`timescale 1ns/100ps
`include "evacc_config.svh"

module event_accumulator_tb;

    localparam int NUM_SURFS       = `EVACC_NUM_SURFS;
    localparam int SAMPLES         = `EVACC_SAMPLES;
    localparam int CHUNKS          = `EVACC_CHUNKS;
    localparam int EVENTS          = 3;
    localparam int CLK_PERIOD_NS   = 100;
    localparam int WORDS_PER_CHUNK = NUM_SURFS * SAMPLES;
    localparam int IN_PER_SURF     = EVENTS * CHUNKS * SAMPLES;
    localparam int TOTAL_OUT       = EVENTS * CHUNKS * WORDS_PER_CHUNK;
    // eight cycles of slack for every output word
    localparam int WATCHDOG_NS     = TOTAL_OUT * 8 * CLK_PERIOD_NS;

    logic                                  memclk;
    logic                                  memresetn;
    evacc_pkg::surf_beat_t [NUM_SURFS-1:0] surf_i;
    logic [NUM_SURFS-1:0]                  surf_ready_o;
    evacc_pkg::payload_t                   payload_o;
    logic                                  payload_has_space_i;

    logic [31:0]         lfsr_state;
    int                  taken_count [NUM_SURFS];
    int                  space_hold;
    int                  out_count;
    int                  stall_words;
    int                  mismatch_count;
    int                  fail_count;
    evacc_pkg::payload_t expected;

    event_accumulator dut0 (
        .memclk              (memclk),
        .memresetn           (memresetn),
        .surf_i              (surf_i),
        .surf_ready_o        (surf_ready_o),
        .payload_o           (payload_o),
        .payload_has_space_i (payload_has_space_i)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit, newest bit at the bottom
    function automatic int draw_bits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = (r << 1) | int'(lfsr_state[0]);
        end
        return r;
    endfunction

    // marker bytes between the fields make a shifted word stand out
    function automatic logic [`EVACC_DATA_W-1:0] make_word(input int e, input int c,
                                                          input int s, input int k);
        return {8'hea, 8'(e), 8'hc4, 8'(c), 8'h5f, 8'(s), 16'(k)};
    endfunction

    // i counts the words of one SURF across all events
    function automatic logic [`EVACC_DATA_W-1:0] input_word(input int s, input int i);
        return make_word(i / (CHUNKS * SAMPLES), (i / SAMPLES) % CHUNKS, s, i % SAMPLES);
    endfunction

    // output order is chunk by chunk, SURF 0 to 6, samples 0 to 383
    function automatic evacc_pkg::payload_t expected_payload(input int n);
        evacc_pkg::payload_t p;
        int                  e;
        int                  c;
        int                  s;
        int                  k;
        e = n / (CHUNKS * WORDS_PER_CHUNK);
        c = (n / WORDS_PER_CHUNK) % CHUNKS;
        s = (n / SAMPLES) % NUM_SURFS;
        k = n % SAMPLES;
        p.valid       = 1'b1;
        p.last        = (k == SAMPLES - 1);
        p.ident.chunk = evacc_pkg::chunk_num_t'(c);
        p.ident.surf  = evacc_pkg::surf_idx_t'(s);
        p.data        = make_word(e, c, s, k);
        return p;
    endfunction

    initial begin
        memclk = 1'b0;
        forever #(CLK_PERIOD_NS / 2) memclk = ~memclk;
    end

    // stimulus, all random draws in one process so their order is fixed
    always @(posedge memclk) begin
        if (memresetn) begin
            for (int s = 0; s < NUM_SURFS; s++) begin
                if (surf_i[s].valid && surf_ready_o[s]) begin
                    taken_count[s]++;
                end
                // a presented word stays until it is taken
                if (!(surf_i[s].valid && !surf_ready_o[s])) begin
                    surf_i[s].valid <= 1'b0;
                    if (taken_count[s] < IN_PER_SURF) begin
                        // three in four cycles carry a word
                        if (draw_bits(2) != 0) begin
                            surf_i[s].valid <= 1'b1;
                            surf_i[s].data  <= input_word(s, taken_count[s]);
                        end
                    end
                end
            end
            // long low spells fill both banks and stall the writer
            if (space_hold == 0) begin
                if (payload_has_space_i) begin
                    payload_has_space_i <= 1'b0;
                    space_hold = draw_bits(12);
                end else begin
                    payload_has_space_i <= 1'b1;
                    space_hold = draw_bits(10);
                end
            end else begin
                space_hold--;
            end
        end
    end

    // comparison against the expected stream
    always @(posedge memclk) begin
        if (memresetn) begin
            for (int s = 0; s < NUM_SURFS; s++) begin
                if (surf_ready_o[s] && !surf_i[s].valid) begin
                    fail_count++;
                    $display("Error at %0t ns: surf_ready_o[%0d] high with no valid word",
                             $time, s);
                end
            end
            if (payload_o.valid) begin
                if (out_count >= TOTAL_OUT) begin
                    fail_count++;
                    $display("Error at %0t ns: extra output word beyond the expected %0d",
                             $time, TOTAL_OUT);
                end else begin
                    expected = expected_payload(out_count);
                    if (payload_o.data !== expected.data) begin
                        mismatch_count++;
                        $display("Mismatch at %0t ns: word %0d data %h, expected %h",
                                 $time, out_count, payload_o.data, expected.data);
                    end
                    if (payload_o.ident !== expected.ident) begin
                        mismatch_count++;
                        $display("Mismatch at %0t ns: word %0d ident %h, expected %h",
                                 $time, out_count, payload_o.ident, expected.ident);
                    end
                    if (payload_o.last !== expected.last) begin
                        mismatch_count++;
                        $display("Mismatch at %0t ns: word %0d last %b, expected %b",
                                 $time, out_count, payload_o.last, expected.last);
                    end
                end
                out_count++;
            end
            // words seen while the consumer reports no space
            if (payload_has_space_i) begin
                stall_words = 0;
            end else if (payload_o.valid) begin
                stall_words++;
                if (stall_words == WORDS_PER_CHUNK + 1) begin
                    fail_count++;
                    $display("Error at %0t ns: more than one chunk sent after space fell",
                             $time);
                end
            end
        end
    end

    initial begin
        memresetn           = 1'b0;
        surf_i              = '0;
        payload_has_space_i = 1'b0;
        lfsr_state          = 32'h23ed_d009;
        space_hold          = 0;
        out_count           = 0;
        stall_words         = 0;
        mismatch_count      = 0;
        fail_count          = 0;
        foreach (taken_count[s]) begin
            taken_count[s] = 0;
        end
        repeat (5) @(posedge memclk);
        memresetn <= 1'b1;
        wait (out_count == TOTAL_OUT);
        // idle tail so a stray extra word still shows up
        repeat (50) @(posedge memclk);
        for (int s = 0; s < NUM_SURFS; s++) begin
            if (taken_count[s] != IN_PER_SURF) begin
                fail_count++;
                $display("Error: SURF %0d handed over %0d words instead of %0d",
                         s, taken_count[s], IN_PER_SURF);
            end
        end
        $display("Finished: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        fail_count++;
        $display("Timeout: only %0d of %0d output words after %0d ns",
                 out_count, TOTAL_OUT, WATCHDOG_NS);
        $display("Finished: %0d mismatches, %0d other errors", mismatch_count, fail_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

/* event_accumulator.f */
+incdir+include
source/evacc_pkg.sv
source/surf_write_sequencer.sv
source/chunk_buffer.sv
source/chunk_queue.sv
source/chunk_readout.sv
source/event_accumulator.sv
tests/event_accumulator_tb.sv

/* Makefile */
# Verilator build and run for the event accumulator

VERILATOR  ?= verilator
TB_TOP     ?= event_accumulator_tb
RTL_TOP    ?= event_accumulator
FILELIST   ?= event_accumulator.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS := source/evacc_pkg.sv source/surf_write_sequencer.sv source/chunk_buffer.sv \
            source/chunk_queue.sv source/chunk_readout.sv source/event_accumulator.sv
ALL_SRCS := $(RTL_SRCS) tests/event_accumulator_tb.sv include/evacc_config.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(ALL_SRCS)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Some tests failed" $(LOG) || ! grep -q "All tests passed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) +incdir+include $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
